//--- compile.f
design/legalizer_pkg.sv
design/page_splitter.sv
design/burst_channel.sv
design/rw_flow_ctrl.sv
design/legalizer_top.sv
sim/legalizer_checker.sv
sim/tb_legalizer.sv

//--- design/burst_channel.sv
// ---------------------------------------------------------------------------
// Burst channel
// Mutable transfer state of one side, emits one legal burst per step
// ---------------------------------------------------------------------------

`default_nettype none

module burst_channel #(
    parameter int unsigned PAGE_SIZE = 1024
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     load_i,
    input  legalizer_pkg::addr_t     addr_i,
    input  legalizer_pkg::len_t      length_i,
    input  legalizer_pkg::side_opt_t opt_i,
    input  legalizer_pkg::page_len_t limit_i,
    input  logic                     enable_i,
    input  logic                     kill_i,
    output legalizer_pkg::page_len_t bytes_to_pb_o,
    output legalizer_pkg::burst_t    burst_o,
    output logic                     done_o,
    output logic                     busy_o
);
    import legalizer_pkg::*;

    // Remaining part of the transfer on this side
    typedef struct packed {
        len_t  length;
        addr_t addr;
        logic  valid;
    } chan_state_t;

    chan_state_t state_d;
    chan_state_t state_q;
    side_opt_t   opt_q;

    page_len_t   num_bytes;
    offset_t     addr_offset;
    logic        done;

    // -------------------------------------------------------------------------
    // Boundary distance of the current address
    // -------------------------------------------------------------------------
    page_splitter #(
        .PAGE_SIZE     (PAGE_SIZE)
    ) u_page_splitter (
        .addr_i        (state_q.addr),
        .opt_i         (opt_q),
        .bytes_to_pb_o (bytes_to_pb_o)
    );

    // -------------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------------
    always_comb begin : proc_legalize
        state_d = state_q;
        done    = 1'b0;
        // More left than the limit allows
        if (state_q.length > len_t'(limit_i)) begin
            num_bytes      = limit_i;
            state_d.length = state_q.length - len_t'(limit_i);
            state_d.addr   = state_q.addr + addr_t'(limit_i);
        end else begin
            // Remainder fits, this is the final burst
            num_bytes = page_len_t'(state_q.length);
            state_d   = '0;
            done      = 1'b1;
        end
        // Drop whatever is in flight
        if (kill_i) begin
            state_d = '0;
        end
        // New request wins over kill
        if (load_i) begin
            state_d = '{length: length_i, addr: addr_i, valid: 1'b1};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= '0;
            opt_q   <= '0;
        end else if (enable_i) begin
            state_q <= state_d;
            // Options only change with a new request
            if (load_i) begin
                opt_q <= opt_i;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Burst geometry
    // -------------------------------------------------------------------------
    assign addr_offset = state_q.addr[OFFSET_WIDTH-1:0];

    assign burst_o = '{
        addr:      {state_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}},
        offset:    addr_offset,
        tailer:    offset_t'(num_bytes + page_len_t'(addr_offset)),
        num_bytes: num_bytes,
        is_single: (num_bytes <= page_len_t'(STRB_WIDTH)),
        last:      done
    };

    assign done_o = done;
    assign busy_o = state_q.valid;

    // Limit from the flow control and the splitter always allow progress
    a_busy_nonempty : assert property (@(posedge clk_i) disable iff (reset_i)
        busy_o |-> (burst_o.num_bytes != '0))
        else $error("busy channel emits an empty burst");

endmodule

`default_nettype wire

//--- design/legalizer_pkg.sv
// ---------------------------------------------------------------------------
// DMA transfer legalizer shared definitions
// Bus and address widths, page limits, request, option and burst structs
// ---------------------------------------------------------------------------

`default_nettype none

package legalizer_pkg;

    // -------------------------------------------------------------------------
    // Widths and limits
    // -------------------------------------------------------------------------
    localparam int unsigned DATA_WIDTH    = 32;
    localparam int unsigned ADDR_WIDTH    = 24;
    // Bytes per data beat
    localparam int unsigned STRB_WIDTH    = DATA_WIDTH / 8;
    localparam int unsigned OFFSET_WIDTH  = $clog2(STRB_WIDTH);
    // Upper bound for any page configuration
    localparam int unsigned MAX_PAGE_SIZE = 4096;

    // -------------------------------------------------------------------------
    // Scalar types
    // -------------------------------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0]            addr_t;
    typedef logic [OFFSET_WIDTH-1:0]          offset_t;
    typedef logic [ADDR_WIDTH-1:0]            len_t;
    // One extra bit so a full page count fits
    typedef logic [$clog2(MAX_PAGE_SIZE):0]   page_len_t;
    // Log2 of the beat count of a reduced burst
    typedef logic [2:0]                       max_llen_t;

    // Per-side burst options
    typedef struct packed {
        logic      reduce_len;
        max_llen_t max_llen;
    } side_opt_t;

    // Generic 1D copy request
    typedef struct packed {
        len_t      length;
        addr_t     src_addr;
        addr_t     dst_addr;
        side_opt_t src_opt;
        side_opt_t dst_opt;
        logic      decouple_rw;
    } xfer_req_t;

    // One legal burst, geometry for the data path
    typedef struct packed {
        addr_t     addr;       // word aligned
        offset_t   offset;     // first valid byte in the first beat
        offset_t   tailer;     // end position in the last beat
        page_len_t num_bytes;
        logic      is_single;  // fits in one beat
        logic      last;       // final burst of the transfer
    } burst_t;

endpackage

`default_nettype wire

//--- design/legalizer_top.sv
// ---------------------------------------------------------------------------
// DMA transfer legalizer top level
// Cuts a 1D copy request into page-safe read and write burst sequences
// ---------------------------------------------------------------------------

`default_nettype none

module legalizer_top #(
    parameter int unsigned PAGE_SIZE = 1024
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  legalizer_pkg::xfer_req_t xfer_req_i,
    input  logic                     valid_i,
    input  logic                     flush_i,
    input  logic                     kill_i,
    input  logic                     r_ready_i,
    input  logic                     w_ready_i,
    output logic                     ready_o,
    output logic                     r_valid_o,
    output logic                     w_valid_o,
    output logic                     r_busy_o,
    output logic                     w_busy_o,
    output legalizer_pkg::burst_t    r_burst_o,
    output legalizer_pkg::burst_t    w_burst_o
);
    import legalizer_pkg::*;

    // Boundary distances towards the flow control
    page_len_t r_bytes_to_pb;
    page_len_t w_bytes_to_pb;
    // Byte limits back to the channels
    page_len_t r_limit;
    page_len_t w_limit;

    logic      r_enable;
    logic      w_enable;
    logic      r_done;
    logic      w_done;
    logic      load;

    // -------------------------------------------------------------------------
    // Read side, source address
    // -------------------------------------------------------------------------
    burst_channel #(
        .PAGE_SIZE     (PAGE_SIZE)
    ) u_read_channel (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .load_i        (load),
        .addr_i        (xfer_req_i.src_addr),
        .length_i      (xfer_req_i.length),
        .opt_i         (xfer_req_i.src_opt),
        .limit_i       (r_limit),
        .enable_i      (r_enable),
        .kill_i        (kill_i),
        .bytes_to_pb_o (r_bytes_to_pb),
        .burst_o       (r_burst_o),
        .done_o        (r_done),
        .busy_o        (r_busy_o)
    );

    // -------------------------------------------------------------------------
    // Write side, destination address
    // -------------------------------------------------------------------------
    burst_channel #(
        .PAGE_SIZE     (PAGE_SIZE)
    ) u_write_channel (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .load_i        (load),
        .addr_i        (xfer_req_i.dst_addr),
        .length_i      (xfer_req_i.length),
        .opt_i         (xfer_req_i.dst_opt),
        .limit_i       (w_limit),
        .enable_i      (w_enable),
        .kill_i        (kill_i),
        .bytes_to_pb_o (w_bytes_to_pb),
        .burst_o       (w_burst_o),
        .done_o        (w_done),
        .busy_o        (w_busy_o)
    );

    // Coupling, stalls and request acceptance
    rw_flow_ctrl u_flow_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .valid_i         (valid_i),
        .req_decouple_i  (xfer_req_i.decouple_rw),
        .r_ready_i       (r_ready_i),
        .w_ready_i       (w_ready_i),
        .flush_i         (flush_i),
        .kill_i          (kill_i),
        .r_bytes_to_pb_i (r_bytes_to_pb),
        .w_bytes_to_pb_i (w_bytes_to_pb),
        .r_done_i        (r_done),
        .w_done_i        (w_done),
        .r_busy_i        (r_busy_o),
        .w_busy_i        (w_busy_o),
        .r_limit_o       (r_limit),
        .w_limit_o       (w_limit),
        .r_enable_o      (r_enable),
        .w_enable_o      (w_enable),
        .load_o          (load),
        .ready_o         (ready_o),
        .r_valid_o       (r_valid_o),
        .w_valid_o       (w_valid_o)
    );

endmodule

`default_nettype wire

//--- design/page_splitter.sv
// ---------------------------------------------------------------------------
// Page splitter
// Distance in bytes from an address to the next page or burst-limit boundary
// ---------------------------------------------------------------------------

`default_nettype none

module page_splitter #(
    parameter int unsigned PAGE_SIZE = 1024
) (
    input  legalizer_pkg::addr_t     addr_i,
    input  legalizer_pkg::side_opt_t opt_i,
    output legalizer_pkg::page_len_t bytes_to_pb_o
);
    import legalizer_pkg::*;

    // Page size in counter width
    localparam page_len_t PAGE_BYTES = page_len_t'(PAGE_SIZE);

    page_len_t burst_bytes;
    page_len_t bound_bytes;
    page_len_t pos_in_bound;

    always_comb begin : proc_boundary
        // Reduced burst limit is beats times beat width
        burst_bytes = page_len_t'(STRB_WIDTH) << opt_i.max_llen;
        bound_bytes = PAGE_BYTES;
        // Only the tighter limit applies
        if (opt_i.reduce_len && (burst_bytes < PAGE_BYTES)) begin
            bound_bytes = burst_bytes;
        end
        // Boundary is a power of two, so a mask gives the position
        pos_in_bound = page_len_t'(addr_i) & (bound_bytes - 1'b1);
    end

    assign bytes_to_pb_o = bound_bytes - pos_in_bound;

endmodule

`default_nettype wire

//--- design/rw_flow_ctrl.sv
// ---------------------------------------------------------------------------
// Read/write flow control
// Coupling mode, per-side limits and enables, valids and request ready
// ---------------------------------------------------------------------------

`default_nettype none

module rw_flow_ctrl (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     valid_i,
    input  logic                     req_decouple_i,
    input  logic                     r_ready_i,
    input  logic                     w_ready_i,
    input  logic                     flush_i,
    input  logic                     kill_i,
    input  legalizer_pkg::page_len_t r_bytes_to_pb_i,
    input  legalizer_pkg::page_len_t w_bytes_to_pb_i,
    input  logic                     r_done_i,
    input  logic                     w_done_i,
    input  logic                     r_busy_i,
    input  logic                     w_busy_i,
    output legalizer_pkg::page_len_t r_limit_o,
    output legalizer_pkg::page_len_t w_limit_o,
    output logic                     r_enable_o,
    output logic                     w_enable_o,
    output logic                     load_o,
    output logic                     ready_o,
    output logic                     r_valid_o,
    output logic                     w_valid_o
);
    import legalizer_pkg::*;

    logic      decouple_q;
    page_len_t c_limit;
    logic      both_ready;

    // Closer of the two boundaries for lockstep progress
    assign c_limit    = (r_bytes_to_pb_i > w_bytes_to_pb_i) ? w_bytes_to_pb_i : r_bytes_to_pb_i;
    assign both_ready = r_ready_i & w_ready_i;

    // Accept when both sides finish this cycle or sit idle
    assign ready_o = r_done_i & w_done_i & both_ready & !flush_i;
    assign load_o  = ready_o & valid_i;

    // -------------------------------------------------------------------------
    // Enables and valids
    // -------------------------------------------------------------------------
    always_comb begin : proc_flow
        if (decouple_q) begin
            // Each side on its own boundary and ready
            r_limit_o  = r_bytes_to_pb_i;
            w_limit_o  = w_bytes_to_pb_i;
            r_enable_o = (r_ready_i & !flush_i) | kill_i;
            w_enable_o = (w_ready_i & !flush_i) | kill_i;
            r_valid_o  = r_busy_i & r_ready_i & !flush_i;
            w_valid_o  = w_busy_i & w_ready_i & !flush_i;
        end else begin
            // Lockstep, one stalled side holds both
            r_limit_o  = c_limit;
            w_limit_o  = c_limit;
            r_enable_o = (both_ready & !flush_i) | kill_i;
            w_enable_o = (both_ready & !flush_i) | kill_i;
            r_valid_o  = r_busy_i & both_ready & !flush_i;
            w_valid_o  = w_busy_i & both_ready & !flush_i;
        end
    end

    // Coupling mode follows each accepted request
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decouple_q <= 1'b0;
        end else if (load_o) begin
            decouple_q <= req_decouple_i;
        end
    end

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------
    // Both channels run the same byte sequence when coupled
    a_coupled_lockstep : assert property (@(posedge clk_i) disable iff (reset_i)
        !decouple_q |-> (r_valid_o == w_valid_o))
        else $error("coupled read and write sides out of step");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the legalizer testbench with Verilator, run it and judge the log

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_legalizer -f compile.f -o tb_legalizer &&
./obj_dir/tb_legalizer > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log && echo "Result: passed" && exit 0 ||
{ echo "Result: failed"; exit 1; }

//--- sim/legalizer_checker.sv
// ---------------------------------------------------------------------------
// Legalizer checker
// Tracks each transfer on both sides and judges the DUT with assertions
// ---------------------------------------------------------------------------

`default_nettype none

module legalizer_checker #(
    parameter int unsigned PAGE_SIZE = 1024
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  legalizer_pkg::xfer_req_t req_i,
    input  logic                     req_valid_i,
    input  logic                     flush_i,
    input  logic                     kill_i,
    input  logic                     r_ready_i,
    input  logic                     w_ready_i,
    input  logic                     ready_i,
    input  logic                     r_valid_i,
    input  logic                     w_valid_i,
    input  logic                     r_busy_i,
    input  logic                     w_busy_i,
    input  legalizer_pkg::burst_t    r_burst_i,
    input  legalizer_pkg::burst_t    w_burst_i,
    output logic                     fail_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import legalizer_pkg::*;

    // Expected progress of one side
    typedef struct packed {
        side_opt_t opt;
        addr_t     next_addr;
        len_t      sum;
        logic      fin;
    } side_book_t;

    side_book_t  r_bk;
    side_book_t  w_bk;
    len_t        len_q;
    logic        killed_q;
    logic        decoupled_q;
    logic        load;
    logic        failed = 1'b0;

    addr_t       r_start;
    addr_t       w_start;
    logic [31:0] r_bound;
    logic [31:0] w_bound;
    logic [31:0] r_end;
    logic [31:0] w_end;
    logic        r_exp_last;
    logic        w_exp_last;
    offset_t     r_exp_tailer;
    offset_t     w_exp_tailer;
    logic        r_exp_single;
    logic        w_exp_single;
    logic        go_coupled;

    assign load   = req_valid_i && ready_i;
    assign fail_o = failed;

    // Page, or the reduced burst when that is smaller
    function automatic logic [31:0] bound_size(input side_opt_t opt);
        logic [31:0] reduced;
        reduced = 32'(STRB_WIDTH) << opt.max_llen;
        if (opt.reduce_len && (reduced < 32'(PAGE_SIZE))) begin
            return reduced;
        end
        return 32'(PAGE_SIZE);
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
        failed = 1'b1;
    endtask

    task automatic log_failure(input string what);
        $display("%s", what);
        failed = 1'b1;
    endtask

    always_comb begin : proc_expect
        // Byte address where each burst really starts
        r_start    = r_burst_i.addr + addr_t'(r_burst_i.offset);
        w_start    = w_burst_i.addr + addr_t'(w_burst_i.offset);
        r_bound    = bound_size(r_bk.opt);
        w_bound    = bound_size(w_bk.opt);
        // End of the burst inside its boundary window
        r_end      = (32'(r_start) % r_bound) + 32'(r_burst_i.num_bytes);
        w_end      = (32'(w_start) % w_bound) + 32'(w_burst_i.num_bytes);
        r_exp_last = (r_bk.sum + len_t'(r_burst_i.num_bytes)) == len_q;
        w_exp_last = (w_bk.sum + len_t'(w_burst_i.num_bytes)) == len_q;
        // Byte position just past the burst, within a beat
        r_exp_tailer = offset_t'((32'(r_start) + 32'(r_burst_i.num_bytes)) % STRB_WIDTH);
        w_exp_tailer = offset_t'((32'(w_start) + 32'(w_burst_i.num_bytes)) % STRB_WIDTH);
        r_exp_single = (32'(r_burst_i.num_bytes) <= STRB_WIDTH);
        w_exp_single = (32'(w_burst_i.num_bytes) <= STRB_WIDTH);
        go_coupled = r_busy_i && r_ready_i && w_ready_i && !flush_i;
    end

    // ------------------------------------------------------------------------
    // Transfer bookkeeping
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            r_bk        <= '0;
            w_bk        <= '0;
            len_q       <= '0;
            killed_q    <= 1'b0;
            decoupled_q <= 1'b0;
        end else begin
            if (r_valid_i) begin
                r_bk.next_addr <= r_start + addr_t'(r_burst_i.num_bytes);
                r_bk.sum       <= r_bk.sum + len_t'(r_burst_i.num_bytes);
                r_bk.fin       <= r_burst_i.last;
            end
            if (w_valid_i) begin
                w_bk.next_addr <= w_start + addr_t'(w_burst_i.num_bytes);
                w_bk.sum       <= w_bk.sum + len_t'(w_burst_i.num_bytes);
                w_bk.fin       <= w_burst_i.last;
            end
            if (kill_i && (r_busy_i || w_busy_i)) begin
                killed_q <= 1'b1;
            end
            // New transfer replaces everything
            if (load) begin
                r_bk        <= '{opt: req_i.src_opt, next_addr: req_i.src_addr,
                                 sum: '0, fin: 1'b0};
                w_bk        <= '{opt: req_i.dst_opt, next_addr: req_i.dst_addr,
                                 sum: '0, fin: 1'b0};
                len_q       <= req_i.length;
                killed_q    <= 1'b0;
                decoupled_q <= req_i.decouple_rw;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Burst checks
    // ------------------------------------------------------------------------
    a_r_boundary : assert property (@(posedge clk_i) disable iff (reset_i)
        r_valid_i |-> (r_end <= r_bound))
        else log_mismatch("read_boundary", $sampled(r_bound), $sampled(r_end));
    a_w_boundary : assert property (@(posedge clk_i) disable iff (reset_i)
        w_valid_i |-> (w_end <= w_bound))
        else log_mismatch("write_boundary", $sampled(w_bound), $sampled(w_end));

    a_r_step : assert property (@(posedge clk_i) disable iff (reset_i)
        r_valid_i |-> (!r_bk.fin && (r_start == r_bk.next_addr)))
        else log_mismatch("read_addr_step", $sampled(r_bk.next_addr), $sampled(r_start));
    a_w_step : assert property (@(posedge clk_i) disable iff (reset_i)
        w_valid_i |-> (!w_bk.fin && (w_start == w_bk.next_addr)))
        else log_mismatch("write_addr_step", $sampled(w_bk.next_addr), $sampled(w_start));

    a_r_last : assert property (@(posedge clk_i) disable iff (reset_i)
        r_valid_i |-> (r_burst_i.last == r_exp_last))
        else log_mismatch("read_last", $sampled(r_exp_last), $sampled(r_burst_i.last));
    a_w_last : assert property (@(posedge clk_i) disable iff (reset_i)
        w_valid_i |-> (w_burst_i.last == w_exp_last))
        else log_mismatch("write_last", $sampled(w_exp_last), $sampled(w_burst_i.last));

    // Aligned address, tailer and single-beat flag
    a_r_geometry : assert property (@(posedge clk_i) disable iff (reset_i)
        r_valid_i |-> ({r_burst_i.addr[OFFSET_WIDTH-1:0], r_burst_i.tailer, r_burst_i.is_single}
                       == {{OFFSET_WIDTH{1'b0}}, r_exp_tailer, r_exp_single}))
        else log_mismatch("read_geometry",
                          $sampled({{OFFSET_WIDTH{1'b0}}, r_exp_tailer, r_exp_single}),
                          $sampled({r_burst_i.addr[OFFSET_WIDTH-1:0], r_burst_i.tailer,
                                    r_burst_i.is_single}));
    a_w_geometry : assert property (@(posedge clk_i) disable iff (reset_i)
        w_valid_i |-> ({w_burst_i.addr[OFFSET_WIDTH-1:0], w_burst_i.tailer, w_burst_i.is_single}
                       == {{OFFSET_WIDTH{1'b0}}, w_exp_tailer, w_exp_single}))
        else log_mismatch("write_geometry",
                          $sampled({{OFFSET_WIDTH{1'b0}}, w_exp_tailer, w_exp_single}),
                          $sampled({w_burst_i.addr[OFFSET_WIDTH-1:0], w_burst_i.tailer,
                                    w_burst_i.is_single}));

    // Idle only after the final burst or a kill
    a_r_closed : assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(r_busy_i) |-> (r_bk.fin || killed_q))
        else log_failure("read side went idle before its final burst");
    a_w_closed : assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(w_busy_i) |-> (w_bk.fin || killed_q))
        else log_failure("write side went idle before its final burst");

    // ------------------------------------------------------------------------
    // Flow checks
    // ------------------------------------------------------------------------
    a_coupled : assert property (@(posedge clk_i) disable iff (reset_i)
        !decoupled_q |-> ({r_valid_i, w_valid_i} == {2{go_coupled}}))
        else log_mismatch("coupled_valid", {2{$sampled(go_coupled)}},
                          $sampled({r_valid_i, w_valid_i}));

    a_flush : assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |-> !(r_valid_i || w_valid_i || ready_i))
        else log_mismatch("flush_stall", 32'h0, $sampled({ready_i, r_valid_i, w_valid_i}));

    a_kill : assert property (@(posedge clk_i) disable iff (reset_i)
        (kill_i && !load) |=> !(r_busy_i || w_busy_i))
        else log_mismatch("kill_idle", 32'h0, $sampled({r_busy_i, w_busy_i}));

    // First cycle out of reset
    a_reset : assert property (@(posedge clk_i)
        $fell(reset_i) |-> ({r_busy_i, w_busy_i, r_valid_i, w_valid_i, ready_i}
                            == {4'b0, r_ready_i && w_ready_i && !flush_i}))
        else log_mismatch("reset_state", $sampled(r_ready_i && w_ready_i && !flush_i),
                          $sampled({r_busy_i, w_busy_i, r_valid_i, w_valid_i, ready_i}));

endmodule

`default_nettype wire

//--- sim/tb_legalizer.sv
// ---------------------------------------------------------------------------
// Legalizer testbench
// Random requests, readies, flush and kill against the DUT and its checker
// ---------------------------------------------------------------------------

`default_nettype none

module tb_legalizer;
    timeunit 1ns;
    timeprecision 1ps;
    import legalizer_pkg::*;

    localparam int unsigned PAGE_SIZE      = 1024;
    localparam int unsigned NUM_REQS       = 200;
    localparam int unsigned CYCLES_PER_REQ = 800;
    localparam logic [31:0] SEED           = 32'h7fc62190;

    // DUT inputs, all defined from time zero
    logic      clk       = 1'b0;
    logic      reset     = 1'b1;
    xfer_req_t xfer_req  = '0;
    logic      req_valid = 1'b0;
    logic      flush     = 1'b0;
    logic      kill      = 1'b0;
    logic      r_ready   = 1'b0;
    logic      w_ready   = 1'b0;

    logic      ready;
    logic      r_valid;
    logic      w_valid;
    logic      r_busy;
    logic      w_busy;
    burst_t    r_burst;
    burst_t    w_burst;
    logic      check_failed;
    logic [31:0] rng;

    always #4 clk = ~clk;

    legalizer_top #(
        .PAGE_SIZE  (PAGE_SIZE)
    ) u_legalizer_top (
        .clk_i      (clk),
        .reset_i    (reset),
        .xfer_req_i (xfer_req),
        .valid_i    (req_valid),
        .flush_i    (flush),
        .kill_i     (kill),
        .r_ready_i  (r_ready),
        .w_ready_i  (w_ready),
        .ready_o    (ready),
        .r_valid_o  (r_valid),
        .w_valid_o  (w_valid),
        .r_busy_o   (r_busy),
        .w_busy_o   (w_busy),
        .r_burst_o  (r_burst),
        .w_burst_o  (w_burst)
    );

    legalizer_checker #(
        .PAGE_SIZE   (PAGE_SIZE)
    ) u_checker (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_i       (xfer_req),
        .req_valid_i (req_valid),
        .flush_i     (flush),
        .kill_i      (kill),
        .r_ready_i   (r_ready),
        .w_ready_i   (w_ready),
        .ready_i     (ready),
        .r_valid_i   (r_valid),
        .w_valid_i   (w_valid),
        .r_busy_i    (r_busy),
        .w_busy_i    (w_busy),
        .r_burst_i   (r_burst),
        .w_burst_i   (w_burst),
        .fail_o      (check_failed)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng   = xorshift32(rng);
        value = rng;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after a failure");
    endtask

    // Fresh request, lengths 1 to 3000 bytes
    task automatic make_request();
        logic [31:0] rnd;
        draw_random(rnd);
        xfer_req.length = len_t'((rnd % 3000) + 1);
        draw_random(rnd);
        xfer_req.src_addr = rnd[ADDR_WIDTH-1:0];
        draw_random(rnd);
        xfer_req.dst_addr = rnd[ADDR_WIDTH-1:0];
        draw_random(rnd);
        xfer_req.src_opt     = rnd[3:0];
        xfer_req.dst_opt     = rnd[7:4];
        xfer_req.decouple_rw = rnd[8];
        req_valid = 1'b1;
    endtask

    // Readies mostly high, flush occasional, kill rare
    task automatic drive_controls();
        logic [31:0] rnd;
        draw_random(rnd);
        r_ready = (rnd[1:0] != 2'b00);
        w_ready = (rnd[3:2] != 2'b00);
        flush   = (rnd[8:4] == 5'd0);
        kill    = (rnd[18:10] == 9'd0);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : proc_stimulus
        int unsigned sent;
        logic        accepted;
        logic        finished;
        sent     = 0;
        finished = 1'b0;
        rng      = SEED;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_controls();
        make_request();
        while (!finished) begin
            // Sampled half a cycle after the inputs settle
            @(negedge clk);
            accepted = req_valid && ready;
            finished = (sent == NUM_REQS) && !r_busy && !w_busy;
            @(posedge clk);
            #1;
            if (accepted) begin
                sent++;
                if (sent < NUM_REQS) begin
                    make_request();
                end else begin
                    req_valid = 1'b0;
                end
            end
            drive_controls();
        end
        if (check_failed) begin
            abort_run("checker reported failures");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // Page size must be a power of two from one beat to the largest page
    initial begin : proc_param_check
        if ((PAGE_SIZE < STRB_WIDTH) || (PAGE_SIZE > MAX_PAGE_SIZE)
            || ((PAGE_SIZE & (PAGE_SIZE - 1)) != 0)) begin
            abort_run("PAGE_SIZE is not a legal page size");
        end
    end

    initial begin : proc_fail_watch
        wait (check_failed);
        abort_run("a DUT check failed");
    end

    initial begin : proc_watchdog
        repeat (NUM_REQS * CYCLES_PER_REQ) @(posedge clk);
        abort_run("watchdog expired before all requests drained");
    end

endmodule

`default_nettype wire
